//--- rtl/spi_host_pkg.sv
// Shared constants of the SPI host controller: register offsets, control bits
// and character width. Modules import it where they need these values.
package spi_host_pkg;

  // character width
  localparam int unsigned spi_max_char      = 32;
  localparam int unsigned spi_char_len_bits = 5;  // 0 encodes a full 32-bit character

  // word offset lives in addr[4:2]
  localparam int unsigned reg_ofs_hi = 4;
  localparam int unsigned reg_ofs_lo = 2;

  localparam logic [2:0] reg_data    = 3'd0;  // write tx, read rx
  localparam logic [2:0] reg_ctrl    = 3'd1;
  localparam logic [2:0] reg_divider = 3'd2;
  localparam logic [2:0] reg_ss      = 3'd3;

  // control register layout
  localparam int unsigned ctrl_char_len_lo = 0;
  localparam int unsigned ctrl_char_len_hi = 4;
  localparam int unsigned ctrl_go          = 8;
  localparam int unsigned ctrl_rx_negedge  = 9;
  localparam int unsigned ctrl_tx_negedge  = 10;
  localparam int unsigned ctrl_lsb         = 11;
  localparam int unsigned ctrl_ie          = 12;
  localparam int unsigned ctrl_ass         = 13;
  localparam int unsigned ctrl_rx_en       = 14;
  localparam int unsigned ctrl_tx_en       = 15;
  localparam int unsigned ctrl_width       = 16;

endpackage

//--- rtl/spi_regs.sv
// Register block of the SPI host: bus decode, divider/ctrl/ss registers and
// registered read data. Also builds the completion interrupts and slave selects.
module spi_regs #(
  parameter int unsigned SsWidth      = 8,
  parameter int unsigned DividerWidth = 16
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  // register bus
  input  logic [7:0]                                addr_i,
  input  logic [31:0]                               wdata_i,
  input  logic [3:0]                                be_i,
  input  logic                                      we_i,
  input  logic                                      re_i,
  output logic [31:0]                               rdata_o,
  output logic                                      intr_rx_o,
  output logic                                      intr_tx_o,
  output logic [SsWidth-1:0]                        ss_o,
  output logic                                      sd_oe_o,
  // shift engine and clock generator status
  input  logic                                      tip_i,
  input  logic                                      last_i,
  input  logic                                      pos_edge_i,
  input  logic [spi_host_pkg::spi_max_char-1:0]      rx_i,
  // settings to the datapath
  output logic                                      go_o,
  output logic [DividerWidth-1:0]                   divider_o,
  output logic [spi_host_pkg::spi_char_len_bits-1:0] char_len_o,
  output logic                                      lsb_o,
  output logic                                      rx_negedge_o,
  output logic                                      tx_negedge_o,
  output logic                                      rx_en_o,
  output logic                                      latch_o
);
  import spi_host_pkg::*;

  logic [DividerWidth-1:0] divider;
  logic [ctrl_width-1:0]   ctrl;
  logic [SsWidth-1:0]      ss;
  logic [2:0]              ofs;
  logic                    wr;
  logic                    sel_data;
  logic                    sel_ctrl;
  logic                    sel_divider;
  logic                    sel_ss;
  logic [31:0]             wmask;      // per-bit write enable from be_i
  logic [31:0]             rdata_d;
  logic                    done;       // final sclk edge of a character
  logic                    ie;
  logic                    ass;
  logic                    tx_en;

  assign ofs = addr_i[reg_ofs_hi:reg_ofs_lo];
  assign wr  = we_i & ~re_i;

  assign sel_data    = wr & (ofs == reg_data);
  assign sel_ctrl    = wr & (ofs == reg_ctrl);
  assign sel_divider = wr & (ofs == reg_divider);
  assign sel_ss      = wr & (ofs == reg_ss);

  assign wmask = {{8{be_i[3]}}, {8{be_i[2]}}, {8{be_i[1]}}, {8{be_i[0]}}};

  assign done = tip_i & last_i & pos_edge_i;

  // divider, frozen during a transfer
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      divider <= '0;
    else if (sel_divider && !tip_i)
      divider <= (divider & ~wmask[DividerWidth-1:0]) |
                 (wdata_i[DividerWidth-1:0] & wmask[DividerWidth-1:0]);
  end

  // control register; go self-clears when the character completes
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      ctrl <= '0;
    else if (sel_ctrl && !tip_i)
      ctrl <= (ctrl & ~wmask[ctrl_width-1:0]) | (wdata_i[ctrl_width-1:0] & wmask[ctrl_width-1:0]);
    else if (done)
      ctrl[ctrl_go] <= 1'b0;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      ss <= '0;  // nothing selected
    else if (sel_ss && !tip_i)
      ss <= (ss & ~wmask[SsWidth-1:0]) | (wdata_i[SsWidth-1:0] & wmask[SsWidth-1:0]);
  end

  assign go_o         = ctrl[ctrl_go];
  assign char_len_o   = ctrl[ctrl_char_len_hi:ctrl_char_len_lo];
  assign lsb_o        = ctrl[ctrl_lsb];
  assign rx_negedge_o = ctrl[ctrl_rx_negedge];
  assign tx_negedge_o = ctrl[ctrl_tx_negedge];
  assign rx_en_o      = ctrl[ctrl_rx_en];
  assign ie           = ctrl[ctrl_ie];
  assign ass          = ctrl[ctrl_ass];
  assign tx_en        = ctrl[ctrl_tx_en];
  assign divider_o    = divider;

  // tx word goes straight into the shift register
  assign latch_o = sel_data & tx_en;

  // read mux, zero extended
  always_comb
  begin
    rdata_d = '0;
    case (ofs)
      reg_data:    rdata_d = rx_i;
      reg_ctrl:    rdata_d[ctrl_width-1:0] = ctrl;
      reg_divider: rdata_d[DividerWidth-1:0] = divider;
      reg_ss:      rdata_d[SsWidth-1:0] = ss;
      default:     rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      rdata_o <= '0;
    else if (re_i)
      rdata_o <= rdata_d;
  end

  // one-cycle pulses after the last edge
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      intr_tx_o <= 1'b0;
      intr_rx_o <= 1'b0;
    end
    else
    begin
      intr_tx_o <= ie & tx_en & done;
      intr_rx_o <= ie & rx_en_o & done;
    end
  end

  // output enable for a half-duplex data line
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      sd_oe_o <= 1'b0;
    else
      sd_oe_o <= tx_en & ~rx_en_o;
  end

  // active low; in auto mode only asserted during a transfer
  assign ss_o = ~(ss & {SsWidth{tip_i | ~ass}});

endmodule

//--- rtl/spi_clkgen.sv
// Serial clock generator. Divides clk_i by 2*(divider+1) while a transfer runs
// and flags each rising and falling sclk edge one cycle ahead.
module spi_clkgen #(
  parameter int unsigned DividerWidth = 16
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    go_i,
  input  logic                    enable_i,    // transfer in progress
  input  logic                    last_i,      // last bit of the character
  input  logic [DividerWidth-1:0] divider_i,
  output logic                    sclk_o,
  output logic                    pos_edge_o,
  output logic                    neg_edge_o
);

  logic [DividerWidth-1:0] cnt;
  logic                    cnt_zero;
  logic                    cnt_one;
  logic                    div_zero;

  assign cnt_zero = (cnt == '0);
  assign cnt_one  = (cnt == DividerWidth'(1));
  assign div_zero = (divider_i == '0);

  // half-period down counter, held at divider while idle
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      cnt <= '1;
    else if (!enable_i || cnt_zero)
      cnt <= divider_i;
    else
      cnt <= cnt - 1'b1;
  end

  // stop low once the last bit has had its falling edge
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      sclk_o <= 1'b0;
    else if (enable_i && cnt_zero && (!last_i || sclk_o))
      sclk_o <= ~sclk_o;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      pos_edge_o <= 1'b0;
      neg_edge_o <= 1'b0;
    end
    else
    begin
      // divider of zero toggles every cycle, so the strobes follow the level
      pos_edge_o <= (enable_i && !sclk_o && cnt_one) ||
                    (div_zero && sclk_o) ||
                    (div_zero && go_i && !enable_i);  // first edge at start
      neg_edge_o <= (enable_i && sclk_o && cnt_one) ||
                    (div_zero && !sclk_o && enable_i);
    end
  end

endmodule

//--- rtl/spi_shift.sv
// Character shift engine. Holds the tx word, shifts it out MSB or LSB first and
// captures received bits into the same register, which is read back as rx.
module spi_shift (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic [spi_host_pkg::spi_char_len_bits-1:0] len_i,
  input  logic                                      lsb_i,
  input  logic                                      go_i,
  input  logic                                      pos_edge_i,
  input  logic                                      neg_edge_i,
  input  logic                                      rx_negedge_i,
  input  logic                                      tx_negedge_i,
  input  logic                                      rx_en_i,
  input  logic                                      latch_i,
  input  logic [3:0]                                byte_sel_i,
  input  logic [spi_host_pkg::spi_max_char-1:0]      p_in_i,
  input  logic                                      s_in_i,
  output logic                                      tip_o,
  output logic                                      last_o,
  output logic [spi_host_pkg::spi_max_char-1:0]      p_out_o,
  output logic                                      s_out_o
);
  import spi_host_pkg::*;

  logic [spi_max_char-1:0]    data;
  logic [spi_char_len_bits:0] cnt;          // bits left to clock
  logic [spi_char_len_bits:0] full_len;     // len with 0 mapped to 32
  logic [spi_char_len_bits:0] tx_bit_pos;
  logic [spi_char_len_bits:0] rx_bit_pos;
  logic                       tx_clk;
  logic                       rx_clk;

  assign full_len = {~|len_i, len_i};
  assign last_o   = ~|cnt;

  // bit positions relative to the remaining count
  assign tx_bit_pos = lsb_i ? full_len - cnt : cnt - 1'b1;
  assign rx_bit_pos = lsb_i ? full_len - (rx_negedge_i ? cnt + 1'b1 : cnt)
                            : (rx_negedge_i ? cnt : cnt - 1'b1);

  assign tx_clk = tip_o & (tx_negedge_i ? neg_edge_i : pos_edge_i) & ~last_o;
  // the extra rising strobe that ends the transfer must not sample
  assign rx_clk = tip_o & (rx_negedge_i ? neg_edge_i : (pos_edge_i & ~last_o));

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      cnt <= '0;
    else if (!tip_o)
      cnt <= full_len;  // preload for next character
    else if (pos_edge_i && !last_o)
      cnt <= cnt - 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      tip_o <= 1'b0;
    else if (go_i && !tip_o)
      tip_o <= 1'b1;
    else if (tip_o && last_o && pos_edge_i)
      tip_o <= 1'b0;
  end

  // while idle the line shows the first bit
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      s_out_o <= 1'b0;
    else if (tx_clk || !tip_o)
      s_out_o <= data[tx_bit_pos[spi_char_len_bits-1:0]];
  end

  // tx load by byte lanes, rx capture in place
  always_ff @(posedge clk_i)
  begin
    if (latch_i && !tip_o)
    begin
      for (int b = 0; b < spi_max_char / 8; b++)
      begin
        if (byte_sel_i[b])
          data[8*b +: 8] <= p_in_i[8*b +: 8];
      end
    end
    else if (rx_en_i && rx_clk)
      data[rx_bit_pos[spi_char_len_bits-1:0]] <= s_in_i;
  end

  assign p_out_o = data;

endmodule

//--- rtl/spi_host.sv
// SPI host controller top level. Connects the register block, the serial clock
// generator and the shift engine behind a single-cycle strobe register bus.
module spi_host #(
  parameter int unsigned SsWidth      = 8,
  parameter int unsigned DividerWidth = 16
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [7:0]         addr_i,
  input  logic [31:0]        wdata_i,
  input  logic [3:0]         be_i,
  input  logic               we_i,
  input  logic               re_i,
  output logic [31:0]        rdata_o,
  output logic               intr_rx_o,
  output logic               intr_tx_o,
  output logic [SsWidth-1:0] ss_o,
  output logic               sclk_o,
  output logic               sd_o,
  output logic               sd_oe_o,
  input  logic               sd_i
);
  import spi_host_pkg::*;

  logic                         go;
  logic [DividerWidth-1:0]      divider;
  logic [spi_char_len_bits-1:0] char_len;
  logic                         lsb;
  logic                         rx_negedge;
  logic                         tx_negedge;
  logic                         rx_en;
  logic                         latch;
  logic                         tip;
  logic                         last;      // final bit of the character
  logic                         pos_edge;
  logic                         neg_edge;
  logic [spi_max_char-1:0]      rx;

  spi_regs #(
    .SsWidth      (SsWidth),
    .DividerWidth (DividerWidth)
  ) u_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .be_i         (be_i),
    .we_i         (we_i),
    .re_i         (re_i),
    .rdata_o      (rdata_o),
    .intr_rx_o    (intr_rx_o),
    .intr_tx_o    (intr_tx_o),
    .ss_o         (ss_o),
    .sd_oe_o      (sd_oe_o),
    .tip_i        (tip),
    .last_i       (last),
    .pos_edge_i   (pos_edge),
    .rx_i         (rx),
    .go_o         (go),
    .divider_o    (divider),
    .char_len_o   (char_len),
    .lsb_o        (lsb),
    .rx_negedge_o (rx_negedge),
    .tx_negedge_o (tx_negedge),
    .rx_en_o      (rx_en),
    .latch_o      (latch)
  );

  spi_clkgen #(
    .DividerWidth (DividerWidth)
  ) u_clkgen (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .go_i       (go),
    .enable_i   (tip),
    .last_i     (last),
    .divider_i  (divider),
    .sclk_o     (sclk_o),
    .pos_edge_o (pos_edge),
    .neg_edge_o (neg_edge)
  );

  spi_shift u_shift (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .len_i        (char_len),
    .lsb_i        (lsb),
    .go_i         (go),
    .pos_edge_i   (pos_edge),
    .neg_edge_i   (neg_edge),
    .rx_negedge_i (rx_negedge),
    .tx_negedge_i (tx_negedge),
    .rx_en_i      (rx_en),
    .latch_i      (latch),
    .byte_sel_i   (be_i),
    .p_in_i       (wdata_i),
    .s_in_i       (sd_i),
    .tip_o        (tip),
    .last_o       (last),
    .p_out_o      (rx),
    .s_out_o      (sd_o)
  );

endmodule

//--- tb/tb_spi_host.sv
// Testbench for the SPI host controller. Runs loopback transfers over sd_o/sd_i
// and checks registers, sclk rate, interrupts, slave selects and write protection.
module tb_spi_host;
  import spi_host_pkg::*;

  // worst case bit times of all transfers plus bus overhead per transfer
  localparam int n_loop     = 10;
  localparam int max_cycles = n_loop * 32 * 2 * 3 + 8 * 2 * (2 + 4 + 6) + 3 * 8 * 2 * 4 +
                              60 * (n_loop + 6) + 200;
  localparam int n_rate       = 3;
  localparam int rate_div [3] = '{1, 3, 5};

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic [7:0]  addr_i;
  logic [31:0] wdata_i;
  logic [3:0]  be_i;
  logic        we_i;
  logic        re_i;
  logic [31:0] rdata_o;
  logic        intr_rx_o;
  logic        intr_tx_o;
  logic [7:0]  ss_o;
  logic        sclk_o;
  logic        sd_o;
  logic        sd_oe_o;
  logic        sd_i;

  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          rises = 0;       // sclk rising edges in the current transfer
  int          last_rise = 0;
  int          tx_pulses = 0;
  int          rx_pulses = 0;
  int          div_val = 0;     // divider the tb expects in the DUT
  logic [31:0] ctrl_val = '0;
  logic [7:0]  ss_val = '0;
  logic [31:0] rng = 32'h0a40_7f51;
  logic        sclk_q = 1'b0;
  logic [31:0] tx_word = '0;    // character on the wire
  int          tx_len = 32;
  logic        tx_lsb = 1'b0;

  spi_host spi_host_i (.*);

  assign sd_i = sd_o;  // loopback

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] ctrl_word(input logic [4:0] len, input logic lsb,
                                            input logic ie, input logic ass, input logic rx_en);
    logic [31:0] c;
    c = '0;
    c[ctrl_char_len_hi:ctrl_char_len_lo] = len;
    c[ctrl_tx_negedge] = 1'b1;  // drive on falling, sample on rising
    c[ctrl_lsb]        = lsb;
    c[ctrl_ie]         = ie;
    c[ctrl_ass]        = ass;
    c[ctrl_rx_en]      = rx_en;
    c[ctrl_tx_en]      = 1'b1;
    return c;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp)
    else
    begin
      $display("CHECK FAILED %s exp %h got %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic step(input int n);
    repeat (n) @(posedge clk_i);
    #10;
  endtask

  task automatic write_reg(input logic [2:0] ofs, input logic [31:0] data, input logic [3:0] be);
    addr_i  = {3'b000, ofs, 2'b00};
    wdata_i = data;
    be_i    = be;
    we_i    = 1'b1;
    step(1);
    we_i = 1'b0;
    be_i = 4'b0000;
  endtask

  task automatic read_reg(input logic [2:0] ofs, output logic [31:0] data);
    addr_i = {3'b000, ofs, 2'b00};
    re_i   = 1'b1;
    step(1);  // registered read data
    re_i = 1'b0;
    data = rdata_o;
  endtask

  task automatic run_transfer(input logic [31:0] word, input logic [4:0] len, input logic lsb,
                              input logic ie, input logic ass, input logic rx_en,
                              input logic poke_divider);
    logic [31:0] cfg;
    logic [31:0] rd;
    logic [31:0] mask;
    int          n;
    cfg      = ctrl_word(len, lsb, ie, ass, rx_en);
    n        = (len == 5'd0) ? 32 : int'(len);
    mask     = (n == 32) ? 32'hffff_ffff : ((32'h1 << n) - 32'h1);
    ctrl_val = cfg;
    write_reg(reg_ctrl, cfg, 4'b0011);
    write_reg(reg_data, word, 4'b1111);
    if (ass)
      check_value("ss_o idle", 32'h0000_00ff, {24'h0, ss_o});
    rises     = 0;
    tx_pulses = 0;
    rx_pulses = 0;
    tx_word   = word;
    tx_len    = n;
    tx_lsb    = lsb;
    write_reg(reg_ctrl, cfg | (32'h1 << ctrl_go), 4'b0011);
    if (poke_divider)
    begin
      step(2);  // tip is up by now
      write_reg(reg_divider, 32'h0000_7777, 4'b0011);
    end
    read_reg(reg_ctrl, rd);
    while (rd[ctrl_go])
      read_reg(reg_ctrl, rd);
    step(2);
    check_value("ctrl", cfg, rd);
    check_value("sclk_rises", n, rises);
    check_value("intr_tx_pulses", ie ? 1 : 0, tx_pulses);
    check_value("intr_rx_pulses", (ie && rx_en) ? 1 : 0, rx_pulses);
    if (ass)
      check_value("ss_o done", 32'h0000_00ff, {24'h0, ss_o});
    if (rx_en)
    begin
      read_reg(reg_data, rd);
      check_value("rx", word & mask, rd & mask);
    end
  endtask

  task automatic end_test(input string name, input int mark);
    $display("%-16s finished with %0d errors", name, errors - mark);
  endtask

  // watchdog, sclk edge monitor and interrupt counters
  always @(posedge clk_i)
  begin
    cycles++;
    if (cycles > max_cycles)
    begin
      $display("timeout: simulation ran past %0d clock cycles", max_cycles);
      $display("TEST FAILED");
      $finish;
    end
    else
    begin
      if (sclk_o && !sclk_q)
      begin
        if (rises > 0)
          check_value("sclk_period", 2 * (div_val + 1), cycles - last_rise);
        // msb first starts at bit len-1
        if (rises < tx_len)
          check_value("sd_o", {31'h0, tx_word[tx_lsb ? rises : tx_len - 1 - rises]},
                      {31'h0, sd_o});
        rises++;
        last_rise = cycles;
      end
      sclk_q <= sclk_o;
      if (intr_tx_o)
        tx_pulses++;
      if (intr_rx_o)
        rx_pulses++;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) intr_tx_o |=> !intr_tx_o)
  else
  begin
    errors++;
    $display("intr_tx_o stayed high for more than one cycle");
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) intr_rx_o |=> !intr_rx_o)
  else
  begin
    errors++;
    $display("intr_rx_o stayed high for more than one cycle");
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   !ctrl_val[ctrl_ie] |-> !(intr_tx_o || intr_rx_o))
  else
  begin
    errors++;
    $display("an interrupt pulsed while ie was clear");
  end

  // auto select keeps the slaves selected while sclk is active
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (ctrl_val[ctrl_ass] && sclk_o) |-> (ss_o == ~ss_val))
  else
  begin
    errors++;
    $display("CHECK FAILED ss_o exp %h got %h", ~ss_val, ss_o);
  end

  initial
  begin
    int          mark;
    logic [31:0] rd;
    rst_ni  = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    be_i    = '0;
    we_i    = 1'b0;
    re_i    = 1'b0;
    repeat (5) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    step(1);

    mark = errors;
    check_value("ss_o", 32'h0000_00ff, {24'h0, ss_o});
    check_value("intr", 32'h0, {30'h0, intr_tx_o, intr_rx_o});
    check_value("sd_oe_o", 32'h0, {31'h0, sd_oe_o});
    check_value("rdata_o", 32'h0, rdata_o);
    write_reg(reg_divider, 32'h1234_a5c3, 4'b0011);
    write_reg(reg_divider, 32'h0000_5600, 4'b0010);
    read_reg(reg_divider, rd);
    check_value("divider", 32'h0000_56c3, rd);  // byte 1 from the second write
    write_reg(reg_ss, 32'hffff_ff5a, 4'b0001);
    ss_val = 8'h5a;
    read_reg(reg_ss, rd);
    check_value("ss", 32'h0000_005a, rd);
    write_reg(reg_ctrl, 32'h0000_ff08, 4'b0001);
    write_reg(reg_ctrl, 32'h0000_c0ff, 4'b0010);
    ctrl_val = 32'h0000_c008;  // low byte of the first write, high byte of the second
    read_reg(reg_ctrl, rd);
    check_value("ctrl", ctrl_val, rd);
    for (int ofs = 4; ofs < 8; ofs++)
    begin
      read_reg(3'(ofs), rd);
      check_value("unused", 32'h0, rd);
    end
    end_test("reset_regs", mark);

    mark = errors;
    write_reg(reg_divider, 32'h0000_0002, 4'b0011);
    div_val = 2;
    for (int i = 0; i < n_loop; i++)
    begin
      rng = xorshift(rng);
      rd  = rng;
      rng = xorshift(rng);
      run_transfer(rd, rng[4:0], i[0], 1'b0, 1'b0, 1'b1, 1'b0);
    end
    end_test("loopback", mark);

    mark = errors;
    for (int k = 0; k < n_rate; k++)
    begin
      write_reg(reg_divider, 32'(rate_div[k]), 4'b0011);
      div_val = rate_div[k];
      rng = xorshift(rng);
      run_transfer(rng, 5'd8, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    end
    end_test("sclk_rate", mark);

    mark = errors;
    write_reg(reg_divider, 32'h0000_0003, 4'b0011);
    div_val = 3;
    rng = xorshift(rng);
    run_transfer(rng, 5'd8, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
    rng = xorshift(rng);
    run_transfer(rng, 5'd8, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);  // tx only
    end_test("completion", mark);

    mark = errors;
    write_reg(reg_ss, 32'h0000_0021, 4'b0001);
    ss_val = 8'h21;
    check_value("ss_o", {24'h0, ~ss_val}, {24'h0, ss_o});
    rng = xorshift(rng);
    run_transfer(rng, 5'd8, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1);
    read_reg(reg_divider, rd);
    check_value("divider", 32'h0000_0003, rd);
    ctrl_val = 32'h1 << ctrl_tx_en;
    write_reg(reg_ctrl, ctrl_val, 4'b0011);
    step(1);
    check_value("sd_oe_o", 32'h1, {31'h0, sd_oe_o});
    ctrl_val = (32'h1 << ctrl_tx_en) | (32'h1 << ctrl_rx_en);
    write_reg(reg_ctrl, ctrl_val, 4'b0011);
    step(1);
    check_value("sd_oe_o", 32'h0, {31'h0, sd_oe_o});
    ctrl_val = 32'h1 << ctrl_rx_en;
    write_reg(reg_ctrl, ctrl_val, 4'b0011);
    step(1);
    check_value("sd_oe_o", 32'h0, {31'h0, sd_oe_o});
    end_test("select_protect", mark);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- spi_host.f
rtl/spi_host_pkg.sv
rtl/spi_regs.sv
rtl/spi_clkgen.sv
rtl/spi_shift.sv
rtl/spi_host.sv
tb/tb_spi_host.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_spi_host -f spi_host.f -o sim_tb || exit 1
out=$(./obj_dir/sim_tb) || { printf '%s\n' "$out"; echo "simulator exited with an error"; exit 1; }
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'TEST OK' && echo "PASS" || { echo "FAIL"; exit 1; }
